// ==== src/flight_defs.svh ====
// Timing, stick scaling and motor limit constants, included by every RTL file that needs them
`ifndef FLIGHT_DEFS_SVH
`define FLIGHT_DEFS_SVH

// sys_clk cycles in one microsecond
`define CLKS_PER_US       38

// Receiver pulse to stick value scaling
`define RC_MIN_US         1000
`define RC_SPAN_SHIFT     2
`define RC_MAX_VAL        250
`define RC_CENTER         125

// Arming and control gain
`define THROTTLE_ARM_MIN  10
`define GAIN_SHIFT        1

// Motor rate ceiling and ESC pulse timing
`define MOTOR_MAX         250
`define ESC_MIN_US        1000
`define ESC_US_PER_STEP   4
`define PWM_FRAME_US      2500

`endif

// ==== src/flight_pkg.sv ====
// Shared flight controller types, referenced by scoped name from the RTL and the testbench
package flight_pkg;

    // Scaled receiver stick value, 0 to 250
    typedef logic [7:0] stick_t;

    // IMU angle or rate, already in stick units
    typedef logic signed [15:0] imu_t;

    // Axis correction after gain shift and saturation
    typedef logic signed [11:0] corr_t;

    // Motor rate, 0 to 250
    typedef logic [7:0] motor_rate_t;

    // Microsecond count for pulse widths and frames
    typedef logic [14:0] us_count_t;

    // Control pass sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_MIX,
        SEQ_COMMIT
    } seq_state_t;

endpackage

// ==== src/us_tick_timer.sv ====
// Microsecond time base, one sys_clk wide tick shared by the pulse captures and the ESC frame
`include "flight_defs.svh"

module us_tick_timer (
    input  logic sys_clk,
    input  logic resetn,
    output logic us_tick
);

    logic [5:0] div_cnt;

    // Tick on the last count of each microsecond
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            div_cnt <= '0;
            us_tick <= 1'b0;
        end else if (div_cnt == 6'(`CLKS_PER_US - 1)) begin
            div_cnt <= '0;
            us_tick <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            us_tick <= 1'b0;
        end
    end

    // Tick is a single cycle strobe
    tick_single_cycle: assert property (
        @(posedge sys_clk) disable iff (!resetn)
        us_tick |=> !us_tick
    );

endmodule

// ==== src/rc_pulse_capture.sv ====
// Measures one receiver channel pulse width in microseconds and scales it to a 0-250 stick value
`include "flight_defs.svh"

module rc_pulse_capture (
    input  logic               sys_clk,
    input  logic               resetn,
    input  logic               us_tick,
    input  logic               pulse,
    output flight_pkg::stick_t stick_val
);

    logic                  pulse_meta;
    logic                  pulse_sync;
    logic                  pulse_prev;
    logic                  pulse_rise;
    logic                  pulse_fall;
    logic                  width_ready;
    flight_pkg::us_count_t width_cnt;
    flight_pkg::us_count_t width_hold;
    flight_pkg::us_count_t width_over;
    flight_pkg::us_count_t width_scaled;
    flight_pkg::stick_t    stick_next;

    // Receiver pulse is asynchronous to sys_clk
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            pulse_meta  <= 1'b0;
            pulse_sync  <= 1'b0;
            pulse_prev  <= 1'b0;
            width_ready <= 1'b0;
        end else begin
            pulse_meta  <= pulse;
            pulse_sync  <= pulse_meta;
            pulse_prev  <= pulse_sync;
            width_ready <= pulse_fall;
        end
    end

    assign pulse_rise = pulse_sync & ~pulse_prev;
    assign pulse_fall = pulse_prev & ~pulse_sync;

    // Width counter restarts on each rising edge, saturates instead of wrapping
    always_ff @(posedge sys_clk) begin
        if (pulse_rise) begin
            width_cnt <= '0;
        end else if (pulse_sync && us_tick && (width_cnt != '1)) begin
            width_cnt <= width_cnt + 1'b1;
        end
        // Snapshot taken on the falling edge
        if (pulse_fall) begin
            width_hold <= width_cnt;
        end
    end

    // Width minus 1000 us, divided down, clamped at both ends
    always_comb begin
        width_over   = width_hold - flight_pkg::us_count_t'(`RC_MIN_US);
        width_scaled = width_over >> `RC_SPAN_SHIFT;
        if (width_hold < flight_pkg::us_count_t'(`RC_MIN_US)) begin
            stick_next = '0;
        end else if (width_scaled > flight_pkg::us_count_t'(`RC_MAX_VAL)) begin
            stick_next = flight_pkg::stick_t'(`RC_MAX_VAL);
        end else begin
            stick_next = width_scaled[7:0];
        end
    end

    // Value holds between pulses
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            stick_val <= '0;
        end else if (width_ready) begin
            stick_val <= stick_next;
        end
    end

    stick_in_range: assert property (
        @(posedge sys_clk) disable iff (!resetn)
        stick_val <= flight_pkg::stick_t'(`RC_MAX_VAL)
    );

endmodule

// ==== src/control_sequencer.sv ====
// Control pass FSM, turns each accepted IMU strobe into one mixer start and one rate commit
module control_sequencer (
    input  logic sys_clk,
    input  logic resetn,
    input  logic imu_valid,
    input  logic mix_done,
    output logic mix_start,
    output logic rates_commit
);

    flight_pkg::seq_state_t state;

    // IMU strobes outside idle are dropped, nothing queues
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            state     <= flight_pkg::SEQ_IDLE;
            mix_start <= 1'b0;
        end else begin
            mix_start <= 1'b0;
            case (state)
                flight_pkg::SEQ_IDLE: begin
                    if (imu_valid) begin
                        state     <= flight_pkg::SEQ_MIX;
                        mix_start <= 1'b1;
                    end
                end
                flight_pkg::SEQ_MIX: begin
                    // Wait out the two mixer stages
                    if (mix_done) begin
                        state <= flight_pkg::SEQ_COMMIT;
                    end
                end
                flight_pkg::SEQ_COMMIT: begin
                    state <= flight_pkg::SEQ_IDLE;
                end
                default: begin
                    state <= flight_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // Commit strobe is the single cycle spent in commit
    assign rates_commit = (state == flight_pkg::SEQ_COMMIT);

    // Mixer only finishes a pass this FSM started
    done_only_in_mix: assert property (
        @(posedge sys_clk) disable iff (!resetn)
        mix_done |-> (state == flight_pkg::SEQ_MIX)
    );

    start_commit_exclusive: assert property (
        @(posedge sys_clk) disable iff (!resetn)
        !(mix_start && rates_commit)
    );

endmodule

// ==== src/motor_mixer.sv ====
// Two stage X-frame mixer, proportional axis corrections then clamped motor rates
`include "flight_defs.svh"

module motor_mixer (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  logic                    mix_start,
    input  flight_pkg::stick_t      throttle_val,
    input  flight_pkg::stick_t      roll_val,
    input  flight_pkg::stick_t      pitch_val,
    input  flight_pkg::stick_t      yaw_val,
    input  flight_pkg::imu_t        roll_angle,
    input  flight_pkg::imu_t        pitch_angle,
    input  flight_pkg::imu_t        yaw_rate,
    output logic                    mix_done,
    output flight_pkg::motor_rate_t motor_1_rate,
    output flight_pkg::motor_rate_t motor_2_rate,
    output flight_pkg::motor_rate_t motor_3_rate,
    output flight_pkg::motor_rate_t motor_4_rate
);

    logic               s1_valid;
    logic               armed;
    flight_pkg::stick_t thr_s1;
    flight_pkg::corr_t  roll_corr_s1;
    flight_pkg::corr_t  pitch_corr_s1;
    flight_pkg::corr_t  yaw_corr_s1;
    logic signed [13:0] thr_ext;
    logic signed [13:0] roll_ext;
    logic signed [13:0] pitch_ext;
    logic signed [13:0] yaw_ext;
    logic signed [13:0] m1_sum;
    logic signed [13:0] m2_sum;
    logic signed [13:0] m3_sum;
    logic signed [13:0] m4_sum;

    // Error from centered stick target, gain shift, saturate to correction range
    function automatic flight_pkg::corr_t axis_corr(input flight_pkg::stick_t stick,
                                                    input flight_pkg::imu_t   meas);
        logic signed [17:0] err;
        logic signed [17:0] corr;
        err  = $signed({10'd0, stick}) - $signed(18'(`RC_CENTER)) - 18'(meas);
        corr = err >>> `GAIN_SHIFT;
        if (corr > 18'sd2047) begin
            return 12'sh7ff;
        end else if (corr < -18'sd2048) begin
            return 12'sh800;
        end else begin
            return corr[11:0];
        end
    endfunction

    // Limit a motor sum to 0..MOTOR_MAX
    function automatic flight_pkg::motor_rate_t clamp_rate(input logic signed [13:0] sum);
        if (sum < 14'sd0) begin
            return '0;
        end else if (sum > $signed(14'(`MOTOR_MAX))) begin
            return flight_pkg::motor_rate_t'(`MOTOR_MAX);
        end else begin
            return sum[7:0];
        end
    endfunction

    // Stage one, inputs sampled at mix_start
    always_ff @(posedge sys_clk) begin
        if (mix_start) begin
            thr_s1        <= throttle_val;
            roll_corr_s1  <= axis_corr(roll_val, roll_angle);
            pitch_corr_s1 <= axis_corr(pitch_val, pitch_angle);
            yaw_corr_s1   <= axis_corr(yaw_val, yaw_rate);
        end
    end

    // Sums are wide enough for three saturated corrections on top of throttle
    assign thr_ext   = $signed({6'd0, thr_s1});
    assign roll_ext  = 14'(roll_corr_s1);
    assign pitch_ext = 14'(pitch_corr_s1);
    assign yaw_ext   = 14'(yaw_corr_s1);

    // X layout, diagonal pairs share yaw sign
    assign m1_sum = thr_ext + pitch_ext + roll_ext - yaw_ext;
    assign m2_sum = thr_ext + pitch_ext - roll_ext + yaw_ext;
    assign m3_sum = thr_ext - pitch_ext - roll_ext - yaw_ext;
    assign m4_sum = thr_ext - pitch_ext + roll_ext + yaw_ext;

    // Low throttle disarms all motors
    assign armed = (thr_s1 >= flight_pkg::stick_t'(`THROTTLE_ARM_MIN));

    // Stage two results
    always_ff @(posedge sys_clk) begin
        if (s1_valid) begin
            motor_1_rate <= armed ? clamp_rate(m1_sum) : '0;
            motor_2_rate <= armed ? clamp_rate(m2_sum) : '0;
            motor_3_rate <= armed ? clamp_rate(m3_sum) : '0;
            motor_4_rate <= armed ? clamp_rate(m4_sum) : '0;
        end
    end

    // Valid bits walk alongside the data
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            mix_done <= 1'b0;
        end else begin
            s1_valid <= mix_start;
            mix_done <= s1_valid;
        end
    end

    done_two_after_start: assert property (
        @(posedge sys_clk) disable iff (!resetn)
        mix_start |-> ##2 mix_done
    );

    done_needs_start: assert property (
        @(posedge sys_clk) disable iff (!resetn)
        mix_done |-> $past(mix_start, 2)
    );

endmodule

// ==== src/esc_pwm_generator.sv ====
// ESC frame timer, holds committed motor rates and drives four 1000-2000 us ESC pulses
`include "flight_defs.svh"

module esc_pwm_generator (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  logic                    us_tick,
    input  logic                    rates_commit,
    input  flight_pkg::motor_rate_t motor_1_rate,
    input  flight_pkg::motor_rate_t motor_2_rate,
    input  flight_pkg::motor_rate_t motor_3_rate,
    input  flight_pkg::motor_rate_t motor_4_rate,
    output logic                    motor_1_pwm,
    output logic                    motor_2_pwm,
    output logic                    motor_3_pwm,
    output logic                    motor_4_pwm,
    output flight_pkg::motor_rate_t held_1_rate,
    output flight_pkg::motor_rate_t held_2_rate,
    output flight_pkg::motor_rate_t held_3_rate,
    output flight_pkg::motor_rate_t held_4_rate
);

    logic                    frame_live;
    flight_pkg::us_count_t   frame_cnt;
    flight_pkg::motor_rate_t rate_in     [4];
    flight_pkg::motor_rate_t shadow      [4];
    flight_pkg::motor_rate_t active      [4];
    flight_pkg::us_count_t   pulse_width [4];
    logic [3:0]              pwm;

    assign rate_in[0] = motor_1_rate;
    assign rate_in[1] = motor_2_rate;
    assign rate_in[2] = motor_3_rate;
    assign rate_in[3] = motor_4_rate;

    // Shadow takes every commit, last one wins
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            for (int i = 0; i < 4; i++) begin
                shadow[i] <= '0;
            end
        end else if (rates_commit) begin
            for (int i = 0; i < 4; i++) begin
                shadow[i] <= rate_in[i];
            end
        end
    end

    // First tick after reset opens frame zero
    // Active rates change only at a frame boundary
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            frame_live <= 1'b0;
            frame_cnt  <= '0;
            for (int i = 0; i < 4; i++) begin
                active[i] <= '0;
            end
        end else if (us_tick) begin
            if (!frame_live || (frame_cnt == flight_pkg::us_count_t'(`PWM_FRAME_US - 1))) begin
                frame_live <= 1'b1;
                frame_cnt  <= '0;
                for (int i = 0; i < 4; i++) begin
                    active[i] <= shadow[i];
                end
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // Pulse high for 1000 us plus 4 us per rate step
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            pulse_width[i] = flight_pkg::us_count_t'(`ESC_MIN_US)
                           + flight_pkg::us_count_t'(active[i])
                           * flight_pkg::us_count_t'(`ESC_US_PER_STEP);
            pwm[i] = frame_live && (frame_cnt < pulse_width[i]);
        end
    end

    assign motor_1_pwm = pwm[0];
    assign motor_2_pwm = pwm[1];
    assign motor_3_pwm = pwm[2];
    assign motor_4_pwm = pwm[3];

    // Commit bypass so the held rate already reads the new value during the commit cycle
    assign held_1_rate = rates_commit ? motor_1_rate : shadow[0];
    assign held_2_rate = rates_commit ? motor_2_rate : shadow[1];
    assign held_3_rate = rates_commit ? motor_3_rate : shadow[2];
    assign held_4_rate = rates_commit ? motor_4_rate : shadow[3];

endmodule

// ==== src/flight_ctrl_top.sv ====
// Quadcopter flight loop top level, receiver capture through mixer to ESC outputs
module flight_ctrl_top (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  logic                    throttle_pulse,
    input  logic                    roll_pulse,
    input  logic                    pitch_pulse,
    input  logic                    yaw_pulse,
    input  logic                    imu_valid,
    input  flight_pkg::imu_t        roll_angle,
    input  flight_pkg::imu_t        pitch_angle,
    input  flight_pkg::imu_t        yaw_rate,
    output logic                    motor_1_pwm,
    output logic                    motor_2_pwm,
    output logic                    motor_3_pwm,
    output logic                    motor_4_pwm,
    output flight_pkg::motor_rate_t motor_1_rate,
    output flight_pkg::motor_rate_t motor_2_rate,
    output flight_pkg::motor_rate_t motor_3_rate,
    output flight_pkg::motor_rate_t motor_4_rate,
    output logic                    update_done
);

    logic                    us_tick;
    logic                    mix_start;
    logic                    mix_done;
    flight_pkg::stick_t      throttle_val;
    flight_pkg::stick_t      roll_val;
    flight_pkg::stick_t      pitch_val;
    flight_pkg::stick_t      yaw_val;
    flight_pkg::motor_rate_t mix_1_rate;
    flight_pkg::motor_rate_t mix_2_rate;
    flight_pkg::motor_rate_t mix_3_rate;
    flight_pkg::motor_rate_t mix_4_rate;

    us_tick_timer us_tick_timer_inst (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .us_tick (us_tick)
    );

    // One capture per receiver channel
    rc_pulse_capture throttle_capture (
        .sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
        .pulse(throttle_pulse), .stick_val(throttle_val)
    );
    rc_pulse_capture roll_capture (
        .sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
        .pulse(roll_pulse), .stick_val(roll_val)
    );
    rc_pulse_capture pitch_capture (
        .sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
        .pulse(pitch_pulse), .stick_val(pitch_val)
    );
    rc_pulse_capture yaw_capture (
        .sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
        .pulse(yaw_pulse), .stick_val(yaw_val)
    );

    // Commit strobe doubles as the pass complete flag
    control_sequencer control_sequencer_inst (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .imu_valid    (imu_valid),
        .mix_done     (mix_done),
        .mix_start    (mix_start),
        .rates_commit (update_done)
    );

    motor_mixer motor_mixer_inst (
        .sys_clk(sys_clk), .resetn(resetn), .mix_start(mix_start),
        .throttle_val(throttle_val), .roll_val(roll_val),
        .pitch_val(pitch_val), .yaw_val(yaw_val),
        .roll_angle(roll_angle), .pitch_angle(pitch_angle), .yaw_rate(yaw_rate),
        .mix_done(mix_done),
        .motor_1_rate(mix_1_rate), .motor_2_rate(mix_2_rate),
        .motor_3_rate(mix_3_rate), .motor_4_rate(mix_4_rate)
    );

    // Held rates brought out for debug visibility
    esc_pwm_generator esc_pwm_generator_inst (
        .sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
        .rates_commit(update_done),
        .motor_1_rate(mix_1_rate), .motor_2_rate(mix_2_rate),
        .motor_3_rate(mix_3_rate), .motor_4_rate(mix_4_rate),
        .motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm),
        .held_1_rate(motor_1_rate), .held_2_rate(motor_2_rate),
        .held_3_rate(motor_3_rate), .held_4_rate(motor_4_rate)
    );

endmodule

// ==== tb/flight_ctrl_tb.sv ====
// Testbench that drives flight_ctrl_top with random receiver frames and checks it by assertions
`include "flight_defs.svh"

module flight_ctrl_tb;

    localparam int RESET_CYCLES = 2;
    localparam int NUM_TESTS    = 11;
    localparam int WIDTH_LO     = 900;
    localparam int WIDTH_HI     = 2100;
    // Lowest throttle width whose stick value still arms the motors
    localparam int ARM_US       = `RC_MIN_US + (`THROTTLE_ARM_MIN << `RC_SPAN_SHIFT);
    localparam int CYCLE_LIMIT  = NUM_TESTS * 4 * `PWM_FRAME_US * `CLKS_PER_US / 4 * 5;

    logic                    sys_clk = 1'b0;
    logic                    resetn;
    logic                    throttle_pulse;
    logic                    roll_pulse;
    logic                    pitch_pulse;
    logic                    yaw_pulse;
    logic                    imu_valid;
    flight_pkg::imu_t        roll_angle;
    flight_pkg::imu_t        pitch_angle;
    flight_pkg::imu_t        yaw_rate;
    logic                    motor_1_pwm;
    logic                    motor_2_pwm;
    logic                    motor_3_pwm;
    logic                    motor_4_pwm;
    flight_pkg::motor_rate_t motor_1_rate;
    flight_pkg::motor_rate_t motor_2_rate;
    flight_pkg::motor_rate_t motor_3_rate;
    flight_pkg::motor_rate_t motor_4_rate;
    logic                    update_done;

    // Stimulus and reference state
    logic [31:0]             lfsr = 32'h4640_9e4e;
    int                      width_us [4];
    flight_pkg::imu_t        imu_val  [3];
    flight_pkg::motor_rate_t exp_rate [4];
    flight_pkg::motor_rate_t rate_obs [4];
    logic                    pwm_obs  [4];
    logic                    esc_armed;
    int                      cyc = 0;
    int                      busy_left = 0;
    flight_pkg::seq_state_t  model_state;
    int                      err_count = 0;
    int                      errs_before = 0;
    int                      pass_count = 0;
    int                      fail_count = 0;

    always #2 sys_clk = ~sys_clk;

    flight_ctrl_top flight_ctrl_top_inst (
        .sys_clk        (sys_clk),
        .resetn         (resetn),
        .throttle_pulse (throttle_pulse),
        .roll_pulse     (roll_pulse),
        .pitch_pulse    (pitch_pulse),
        .yaw_pulse      (yaw_pulse),
        .imu_valid      (imu_valid),
        .roll_angle     (roll_angle),
        .pitch_angle    (pitch_angle),
        .yaw_rate       (yaw_rate),
        .motor_1_pwm    (motor_1_pwm),
        .motor_2_pwm    (motor_2_pwm),
        .motor_3_pwm    (motor_3_pwm),
        .motor_4_pwm    (motor_4_pwm),
        .motor_1_rate   (motor_1_rate),
        .motor_2_rate   (motor_2_rate),
        .motor_3_rate   (motor_3_rate),
        .motor_4_rate   (motor_4_rate),
        .update_done    (update_done)
    );

    assign rate_obs[0] = motor_1_rate;
    assign rate_obs[1] = motor_2_rate;
    assign rate_obs[2] = motor_3_rate;
    assign rate_obs[3] = motor_4_rate;
    assign pwm_obs[0]  = motor_1_pwm;
    assign pwm_obs[1]  = motor_2_pwm;
    assign pwm_obs[2]  = motor_3_pwm;
    assign pwm_obs[3]  = motor_4_pwm;

    // Cycle count that also bounds the run time
    always @(posedge sys_clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Expected sequencer occupancy of four busy cycles per pass
    always @(posedge sys_clk) begin
        if (!resetn) begin
            busy_left <= 0;
        end else if (busy_left != 0) begin
            busy_left <= busy_left - 1;
        end else if (imu_valid) begin
            busy_left <= 4;
        end
    end

    assign model_state = (busy_left == 0) ? flight_pkg::SEQ_IDLE :
                         (busy_left == 1) ? flight_pkg::SEQ_COMMIT : flight_pkg::SEQ_MIX;

    // Galois LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // Receiver width in us to stick value
    function automatic int stick_of_width(input int width);
        int scaled;
        if (width < `RC_MIN_US) begin
            return 0;
        end
        scaled = (width - `RC_MIN_US) >> `RC_SPAN_SHIFT;
        return (scaled > `RC_MAX_VAL) ? `RC_MAX_VAL : scaled;
    endfunction

    // Proportional term as a floor division by the gain
    function automatic int axis_correction(input int stick, input int meas);
        return ((stick - `RC_CENTER) - meas) >>> `GAIN_SHIFT;
    endfunction

    function automatic flight_pkg::motor_rate_t mixed_rate(input int idx, input int thr,
                                                           input int rc, input int pc,
                                                           input int yc);
        int sum;
        if (thr < `THROTTLE_ARM_MIN) begin
            return '0;
        end
        case (idx)
            0:       sum = thr + pc + rc - yc;
            1:       sum = thr + pc - rc + yc;
            2:       sum = thr - pc - rc - yc;
            default: sum = thr - pc + rc + yc;
        endcase
        if (sum < 0) begin
            return '0;
        end
        return (sum > `MOTOR_MAX) ? 8'(`MOTOR_MAX) : 8'(sum);
    endfunction

    // ESC high time in sys_clk cycles
    function automatic int pwm_cycles_for(input int rate);
        return (`ESC_MIN_US + `ESC_US_PER_STEP * rate) * `CLKS_PER_US;
    endfunction

    // Quiet outputs through reset up to the first frame start
    reset_quiet: assert property (
        @(posedge sys_clk)
        (cyc >= 1 && cyc <= RESET_CYCLES + `CLKS_PER_US) |->
        (!motor_1_pwm && !motor_2_pwm && !motor_3_pwm && !motor_4_pwm && !update_done &&
         motor_1_rate == 0 && motor_2_rate == 0 && motor_3_rate == 0 && motor_4_rate == 0)
    ) else begin
        err_count++;
        $display("Mismatch reset state pwm=%h update_done=%h rates=%h %h %h %h expected 0",
                 $sampled({motor_1_pwm, motor_2_pwm, motor_3_pwm, motor_4_pwm}),
                 $sampled(update_done), $sampled(motor_1_rate), $sampled(motor_2_rate),
                 $sampled(motor_3_rate), $sampled(motor_4_rate));
    end

    accept_to_done: assert property (
        @(posedge sys_clk) disable iff (!resetn)
        (imu_valid && model_state == flight_pkg::SEQ_IDLE) |-> ##4 update_done
    ) else begin
        err_count++;
        $display("update_done did not follow an accepted imu_valid after 4 cycles");
    end

    // A strobe during a pass must not give a second commit
    no_extra_done: assert property (
        @(posedge sys_clk) disable iff (!resetn)
        update_done |-> $past(imu_valid && model_state == flight_pkg::SEQ_IDLE, 4)
    ) else begin
        err_count++;
        $display("update_done pulsed without an accepted imu_valid 4 cycles earlier");
    end

    for (genvar i = 0; i < 4; i++) begin : motor_checks
        int high_run;

        // Cycles the pulse has been high so far
        always @(posedge sys_clk) begin
            if (!resetn || !pwm_obs[i]) begin
                high_run <= 0;
            end else begin
                high_run <= high_run + 1;
            end
        end

        rate_after_commit: assert property (
            @(posedge sys_clk) disable iff (!resetn)
            update_done |=> rate_obs[i] == exp_rate[i]
        ) else begin
            err_count++;
            $display("Mismatch motor_%0d_rate expected %h actual %h",
                     i + 1, exp_rate[i], $sampled(rate_obs[i]));
        end

        pwm_width: assert property (
            @(posedge sys_clk) disable iff (!resetn)
            ($fell(pwm_obs[i]) && esc_armed) |->
            (high_run >= pwm_cycles_for(exp_rate[i]) - 1 &&
             high_run <= pwm_cycles_for(exp_rate[i]) + 1)
        ) else begin
            err_count++;
            $display("Mismatch motor_%0d_pwm high cycles expected %h actual %h",
                     i + 1, pwm_cycles_for(exp_rate[i]), $sampled(high_run));
        end

        pwm_ceiling: assert property (
            @(posedge sys_clk) disable iff (!resetn)
            high_run <= pwm_cycles_for(`MOTOR_MAX)
        ) else begin
            err_count++;
            $display("motor_%0d_pwm pulse stayed high longer than 2000 us", i + 1);
        end
    end

    // IMU values random or matched to the chosen sticks
    task automatic pick_imu(input bit neutral);
        logic [31:0] r;
        for (int k = 0; k < 3; k++) begin
            r = rand_bits(9);
            if (neutral) begin
                imu_val[k] = 16'(stick_of_width(width_us[k + 1]) - `RC_CENTER);
            end else begin
                imu_val[k] = {{7{r[8]}}, r[8:0]};
            end
        end
    endtask

    // Random widths with throttle from its own range
    task automatic pick_inputs(input int thr_lo, input int thr_hi, input bit neutral);
        width_us[0] = thr_lo + int'(rand_bits(11)) % (thr_hi - thr_lo + 1);
        for (int k = 1; k < 4; k++) begin
            width_us[k] = WIDTH_LO + int'(rand_bits(11)) % (WIDTH_HI - WIDTH_LO + 1);
        end
        pick_imu(neutral);
    endtask

    // Two receiver frames with every pulse a whole number of microseconds
    task automatic drive_frames();
        int frame_cyc;
        frame_cyc = `PWM_FRAME_US * `CLKS_PER_US;
        // Align to the edge right after a microsecond tick
        @(posedge sys_clk);
        while ((cyc - RESET_CYCLES) % `CLKS_PER_US != 0) begin
            @(posedge sys_clk);
        end
        for (int f = 0; f < 2; f++) begin
            for (int c = 0; c < frame_cyc; c++) begin
                throttle_pulse <= (c < width_us[0] * `CLKS_PER_US);
                roll_pulse     <= (c < width_us[1] * `CLKS_PER_US);
                pitch_pulse    <= (c < width_us[2] * `CLKS_PER_US);
                yaw_pulse      <= (c < width_us[3] * `CLKS_PER_US);
                @(posedge sys_clk);
            end
        end
    endtask

    // Frames, reference rates, then one IMU strobe and an optional second one
    task automatic run_pass(input int second_gap);
        int thr;
        int roll_c;
        int pitch_c;
        int yaw_c;
        drive_frames();
        thr     = stick_of_width(width_us[0]);
        roll_c  = axis_correction(stick_of_width(width_us[1]), int'(imu_val[0]));
        pitch_c = axis_correction(stick_of_width(width_us[2]), int'(imu_val[1]));
        yaw_c   = axis_correction(stick_of_width(width_us[3]), int'(imu_val[2]));
        for (int i = 0; i < 4; i++) begin
            exp_rate[i] = mixed_rate(i, thr, roll_c, pitch_c, yaw_c);
        end
        roll_angle  <= imu_val[0];
        pitch_angle <= imu_val[1];
        yaw_rate    <= imu_val[2];
        imu_valid   <= 1'b1;
        @(posedge sys_clk);
        imu_valid <= (second_gap == 1);
        @(posedge sys_clk);
        imu_valid <= (second_gap == 2);
        @(posedge sys_clk);
        imu_valid <= 1'b0;
        while (update_done !== 1'b1) begin
            @(posedge sys_clk);
        end
        // Room for the rate check and a late commit
        repeat (4) @(posedge sys_clk);
    endtask

    // All four ESC pulses rise together at frame start
    task automatic wait_frame_start();
        while (motor_1_pwm !== 1'b0) begin
            @(posedge sys_clk);
        end
        while (motor_1_pwm !== 1'b1) begin
            @(posedge sys_clk);
        end
    endtask

    task automatic report_test(input string name);
        if (err_count == errs_before) begin
            pass_count++;
            $display("Test %s passed", name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d check errors", name, err_count - errs_before);
        end
        errs_before = err_count;
    endtask

    initial begin
        resetn         <= 1'b0;
        throttle_pulse <= 1'b0;
        roll_pulse     <= 1'b0;
        pitch_pulse    <= 1'b0;
        yaw_pulse      <= 1'b0;
        imu_valid      <= 1'b0;
        roll_angle     <= '0;
        pitch_angle    <= '0;
        yaw_rate       <= '0;
        esc_armed      <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            exp_rate[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge sys_clk);
        resetn <= 1'b1;
        repeat (`CLKS_PER_US + 4) @(posedge sys_clk);
        report_test("reset_state");

        pick_inputs(ARM_US, WIDTH_HI, 1'b0);
        run_pass(1);
        report_test("commit_latency");
        pick_inputs(ARM_US, WIDTH_HI, 1'b0);
        run_pass(2);
        report_test("busy_drop");

        // Both clamp ends of the stick scaling
        width_us = '{WIDTH_HI, WIDTH_LO, WIDTH_HI, 1500};
        pick_imu(1'b1);
        run_pass(0);
        report_test("neutral_clamp");
        for (int t = 0; t < 2; t++) begin
            pick_inputs(ARM_US, WIDTH_HI, 1'b1);
            run_pass(0);
            report_test("neutral_random");
        end

        for (int t = 0; t < 3; t++) begin
            pick_inputs(ARM_US, WIDTH_HI, 1'b0);
            run_pass(0);
            report_test("mix_random");
        end

        pick_inputs(WIDTH_LO, ARM_US - 1, 1'b0);
        run_pass(0);
        report_test("disarm");

        // Skip the frame in flight, then check one whole frame
        pick_inputs(ARM_US, WIDTH_HI, 1'b0);
        run_pass(0);
        wait_frame_start();
        wait_frame_start();
        esc_armed <= 1'b1;
        wait_frame_start();
        esc_armed <= 1'b0;
        report_test("esc_pulse_width");

        $display("Tests passed %0d, failed %0d, check errors %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/flight_pkg.sv
src/us_tick_timer.sv
src/rc_pulse_capture.sv
src/control_sequencer.sv
src/motor_mixer.sv
src/esc_pwm_generator.sv
src/flight_ctrl_top.sv
tb/flight_ctrl_tb.sv
